// File: hdc_defines.svh
`ifndef HDC_DEFINES_SVH
`define HDC_DEFINES_SVH

// hypervector width in bits, kept a multiple of 64
// so the generator can split it into whole lanes
`define HDC_DIM 64

// number of entries in the item table
`define HDC_ITEMS 64

// index width into the item table
`define HDC_ADDR_W 6

// xorshift seed of lane 0, lane k starts from seed xor k
`define HDC_SEED 64'h2545_f491_4f6c_dd1d

`endif

// File: hdc_pkg.sv
`default_nettype none

`include "hdc_defines.svh"

package hdc_pkg;

    // one hypervector
    typedef logic [`HDC_DIM-1:0] hv_t;

    // instruction word as it arrives from the host
    // opcode is one-hot in the upper half
    typedef struct packed {
        logic [15:0] opcode;
        logic [15:0] addr;
    } hdc_instr_t;

    // table read data, with the opcode riding along
    typedef struct packed {
        hv_t         vec;
        logic [15:0] opcode;
    } hdc_operand_t;

    // output bus of the engine
    typedef struct packed {
        hv_t  vec;
        logic store;
        logic last;
    } hdc_result_t;

    // opcode bit positions
    localparam int unsigned OP_LOAD      = 0;
    localparam int unsigned OP_PERM_LOAD = 1;
    localparam int unsigned OP_PERM_ACC  = 2;
    localparam int unsigned OP_XOR_LOAD  = 3;
    localparam int unsigned OP_XOR_COPY  = 4;
    localparam int unsigned OP_STORE     = 5;
    localparam int unsigned OP_COPY      = 6;
    localparam int unsigned OP_LAST      = 7;

endpackage

`default_nettype wire

// File: hv_random_gen.sv
`timescale 1ns/10ps
`default_nettype none

`include "hdc_defines.svh"

module hv_random_gen (
    input  logic        clk,
    input  logic        reset,
    input  logic        advance,
    output hdc_pkg::hv_t rand_vec
);

    // number of 64-bit lanes across one hypervector
    localparam int unsigned LANES = `HDC_DIM / 64;

    // one xorshift64 step
    // shifts 13 left, 7 right, 17 left, each folded back in
    function automatic logic [63:0] xorshift_step(input logic [63:0] x);
        logic [63:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 7);
        s = s ^ (s << 17);
        return s;
    endfunction

    for (genvar k = 0; k < LANES; k++) begin : g_lane

        // lane state, never zero as long as the seed is not zero
        logic [63:0] state;

        always_ff @(posedge clk) begin
            if (reset) begin
                // every lane gets its own start point
                state <= `HDC_SEED ^ 64'(k);
            end else if (advance) begin
                // all lanes step together
                state <= xorshift_step(state);
            end
        end

        // lane 0 sits in the low bits
        assign rand_vec[k*64 +: 64] = state;

    end

endmodule

`default_nettype wire

// File: item_memory.sv
`timescale 1ns/10ps
`default_nettype none

`include "hdc_defines.svh"

module item_memory (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 gen,
    input  logic                 run,
    input  logic [15:0]          gen_addr,
    input  logic [15:0]          item_count,
    input  hdc_pkg::hv_t         rand_vec,
    output logic                 advance,
    input  logic                 instr_v,
    input  hdc_pkg::hdc_instr_t  instr,
    output logic                 operand_v,
    output hdc_pkg::hdc_operand_t operand
);

    import hdc_pkg::*;

    // item table holding one random hypervector per entry
    hv_t table_mem [`HDC_ITEMS];

    logic         wr_ok;
    logic         rd_in_range;
    hdc_operand_t operand_q;
    logic         operand_v_q;

    // writes only while the core is idle
    // the item_count address and entries past the table are skipped
    assign wr_ok = gen && !run && (gen_addr != item_count)
                   && (gen_addr < 16'(`HDC_ITEMS));

    // generator steps on the same edge that takes its value
    assign advance = wr_ok;

    // anything past the table reads as zero
    assign rd_in_range = instr.addr < 16'(`HDC_ITEMS);

    // write port
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            table_mem[gen_addr[`HDC_ADDR_W-1:0]] <= rand_vec;
        end
    end

    // read port registers vector and opcode together
    always_ff @(posedge clk) begin
        if (instr_v) begin
            operand_q.vec    <= rd_in_range ? table_mem[instr.addr[`HDC_ADDR_W-1:0]] : '0;
            operand_q.opcode <= instr.opcode;
        end
    end

    // valid follows an instruction by one cycle while running
    always_ff @(posedge clk) begin
        if (reset || !run) begin
            operand_v_q <= 1'b0;
        end else begin
            operand_v_q <= instr_v;
        end
    end

    assign operand   = operand_q;
    assign operand_v = operand_v_q;

endmodule

`default_nettype wire

// File: hdc_core.sv
`timescale 1ns/10ps
`default_nettype none

module hdc_core (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  run,
    input  logic                  operand_v,
    input  hdc_pkg::hdc_operand_t operand,
    output hdc_pkg::hdc_result_t  result
);

    import hdc_pkg::*;

    // working accumulator
    hv_t acc;

    // saved copy of the accumulator
    hv_t copy;

    // registered output bus
    hdc_result_t result_q;

    // operand fields
    hv_t         vec;
    logic [15:0] op;

    assign vec = operand.vec;
    assign op  = operand.opcode;

    // rotate right by one bit
    // bit 0 wraps to the top
    function automatic hv_t rotr1(input hv_t v);
        return {v[0], v[$bits(hv_t)-1:1]};
    endfunction

    // one opcode per valid operand
    // lowest set bit wins, an empty opcode is a no-op
    always_ff @(posedge clk) begin
        if (reset || !run) begin
            // dropping run starts a fresh encoding
            acc      <= '0;
            copy     <= '0;
            result_q <= '0;
        end else begin
            // store and last are single-cycle pulses
            result_q <= '0;

            if (operand_v) begin
                if (op[OP_LOAD]) begin
                    // plain load of the item
                    acc <= vec;
                end else if (op[OP_PERM_LOAD]) begin
                    // load with one-step permute
                    acc <= rotr1(vec);
                end else if (op[OP_PERM_ACC]) begin
                    // permute what is already held
                    acc <= rotr1(acc);
                end else if (op[OP_XOR_LOAD]) begin
                    // bind item into acc
                    acc <= acc ^ vec;
                end else if (op[OP_XOR_COPY]) begin
                    // bind the saved vector into acc
                    acc <= acc ^ copy;
                end else if (op[OP_STORE]) begin
                    // acc goes out, acc itself is kept
                    result_q.vec   <= acc;
                    result_q.store <= 1'b1;
                end else if (op[OP_COPY]) begin
                    // snapshot acc for a later xor copy
                    copy <= acc;
                end else if (op[OP_LAST]) begin
                    // final store of an encoding
                    result_q.vec   <= acc;
                    result_q.store <= 1'b1;
                    result_q.last  <= 1'b1;
                end
            end
        end
    end

    // vec is already zero on every cycle without a store
    assign result = result_q;

endmodule

`default_nettype wire

// File: hdc_top.sv
`timescale 1ns/10ps
`default_nettype none

module hdc_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 gen,
    input  logic [15:0]          gen_addr,
    input  logic [15:0]          item_count,
    input  logic                 run,
    input  logic                 instr_v,
    input  hdc_pkg::hdc_instr_t  instr,
    output hdc_pkg::hdc_result_t result
);

    import hdc_pkg::*;

    // generator to table
    hv_t          rand_vec;
    logic         advance;

    // table to core
    logic         operand_v;
    hdc_operand_t operand;

    // random hypervector source
    hv_random_gen gen_i (
        .clk      (clk),
        .reset    (reset),
        .advance  (advance),
        .rand_vec (rand_vec)
    );

    // item table, filled while idle, read per instruction
    item_memory mem_i (
        .clk        (clk),
        .reset      (reset),
        .gen        (gen),
        .run        (run),
        .gen_addr   (gen_addr),
        .item_count (item_count),
        .rand_vec   (rand_vec),
        .advance    (advance),
        .instr_v    (instr_v),
        .instr      (instr),
        .operand_v  (operand_v),
        .operand    (operand)
    );

    // opcode execution
    // instr_v to result.store is two cycles
    hdc_core core_i (
        .clk       (clk),
        .reset     (reset),
        .run       (run),
        .operand_v (operand_v),
        .operand   (operand),
        .result    (result)
    );

endmodule

`default_nettype wire

// File: tb_hdc_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "hdc_defines.svh"

module tb_hdc_top;

    import hdc_pkg::*;

    // one pending store expected on the result bus
    typedef struct packed {
        logic [31:0] due;
        hv_t         vec;
        logic        store;
        logic        last;
    } exp_t;

    logic        clk;
    logic        reset;
    logic        gen;
    logic [15:0] gen_addr;
    logic [15:0] item_count;
    logic        run;
    logic        instr_v;
    hdc_instr_t  instr;
    hdc_result_t result;

    hdc_top dut_i (
        .clk        (clk),
        .reset      (reset),
        .gen        (gen),
        .gen_addr   (gen_addr),
        .item_count (item_count),
        .run        (run),
        .instr_v    (instr_v),
        .instr      (instr),
        .result     (result)
    );

    // 100 ns clock
    always #50 clk = ~clk;

    // reference model state
    hv_t  model_table [`HDC_ITEMS];
    hv_t  model_rng;
    hv_t  model_acc;
    hv_t  model_copy;
    hv_t  model_out;
    logic model_run;

    exp_t exp_q[$];
    int   ncyc;
    int   seed;
    int   err_total;
    int   test_err;
    int   tests;
    int   tests_failed;
    int   issue_cyc;

    // xorshift64 step on every lane with lane 0 low
    function automatic hv_t rng_next(input hv_t v);
        logic [63:0] x;
        hv_t         r;
        for (int k = 0; k < `HDC_DIM / 64; k++) begin
            x = v[k*64 +: 64];
            x = x ^ (x << 13);
            x = x ^ (x >> 7);
            x = x ^ (x << 17);
            r[k*64 +: 64] = x;
        end
        return r;
    endfunction

    // one-bit rotate right with bit 0 wrapping to the top
    function automatic hv_t rot_right(input hv_t v);
        return {v[0], v[`HDC_DIM-1:1]};
    endfunction

    task automatic check_value(input string name, input hv_t got, input hv_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h at cycle %0d", name, got, exp, ncyc);
            err_total++;
            test_err++;
        end
    endtask

    // result bus monitor sampled mid-cycle
    always @(negedge clk) begin
        ncyc = ncyc + 1;
        if (!reset) begin
            if (exp_q.size() > 0 && exp_q[0].due == ncyc) begin
                check_value("result.store", hv_t'(result.store), hv_t'(exp_q[0].store));
                check_value("result.last", hv_t'(result.last), hv_t'(exp_q[0].last));
                check_value("result.vec", result.vec, exp_q[0].vec);
                void'(exp_q.pop_front());
            end else begin
                if (result.store) begin
                    $display("unexpected store pulse at cycle %0d", ncyc);
                    err_total++;
                    test_err++;
                end
                // bus stays quiet between stores
                check_value("result.last", hv_t'(result.last), '0);
                check_value("result.vec", result.vec, '0);
            end
        end
    end

    // apply one opcode to the model with the lowest bit first
    task automatic model_exec(input logic [15:0] op, input logic [15:0] addr);
        hv_t v;
        v = (addr < 16'(`HDC_ITEMS)) ? model_table[addr[`HDC_ADDR_W-1:0]] : '0;
        if (op[OP_LOAD])
            model_acc = v;
        else if (op[OP_PERM_LOAD])
            model_acc = rot_right(v);
        else if (op[OP_PERM_ACC])
            model_acc = rot_right(model_acc);
        else if (op[OP_XOR_LOAD])
            model_acc = model_acc ^ v;
        else if (op[OP_XOR_COPY])
            model_acc = model_acc ^ model_copy;
        else if (op[OP_STORE])
            model_out = model_acc;
        else if (op[OP_COPY])
            model_copy = model_acc;
        else if (op[OP_LAST])
            model_out = model_acc;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        instr_v <= 1'b0;
        gen     <= 1'b0;
    endtask

    initial begin
        int          fd;
        int          n_lines;
        int          gap;
        int          tries;
        string       line;
        string       cmd;
        int          opnd;
        int          flags;
        logic [`HDC_DIM-1:0] hexv;
        exp_t        e;

        clk        = 1'b0;
        reset      = 1'b1;
        gen        = 1'b0;
        gen_addr   = '0;
        item_count = '0;
        run        = 1'b0;
        instr_v    = 1'b0;
        instr      = '0;
        ncyc       = 0;
        seed       = 58;
        err_total  = 0;
        test_err   = 0;
        tests      = 0;
        tests_failed = 0;
        issue_cyc  = 0;
        model_acc  = '0;
        model_copy = '0;
        model_out  = '0;
        model_run  = 1'b0;
        for (int i = 0; i < `HDC_ITEMS; i++)
            model_table[i] = '0;
        for (int k = 0; k < `HDC_DIM / 64; k++)
            model_rng[k*64 +: 64] = `HDC_SEED ^ 64'(k);

        // first pass sizes the watchdog
        n_lines = 0;
        fd = $fopen("tb_hdc_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open tb_hdc_input.txt");
            err_total++;
        end else begin
            while ($fgets(line, fd) != 0)
                n_lines++;
            $fclose(fd);
        end

        fork
            begin
                #((n_lines + 1) * 200 * 100);
                $display("timeout, the run did not finish in %0d cycles",
                         (n_lines + 1) * 200);
                $display("Result: FAILED");
                $finish;
            end
        join_none

        repeat (2) @(posedge clk);
        reset <= 1'b0;

        fd = $fopen("tb_hdc_input.txt", "r");
        while (fd != 0 && $fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") continue;
            void'($sscanf(line, "%s %d %h %d", cmd, opnd, hexv, flags));
            if (cmd == "G") begin
                idle_cycle();
                gen        <= 1'b1;
                gen_addr   <= 16'(opnd);
                item_count <= hexv[15:0];
                // accepted writes take the current value and then step
                if (!model_run && 16'(opnd) != hexv[15:0] && opnd < `HDC_ITEMS) begin
                    model_table[opnd] = model_rng;
                    model_rng = rng_next(model_rng);
                end
            end else if (cmd == "R") begin
                idle_cycle();
                run <= opnd[0];
                model_run = opnd[0];
                if (!opnd[0]) begin
                    model_acc  = '0;
                    model_copy = '0;
                end
            end else if (cmd == "I") begin
                gap = flags ? ($unsigned($random(seed)) % 4) : 0;
                repeat (gap) idle_cycle();
                @(posedge clk);
                gen     <= 1'b0;
                instr_v <= 1'b1;
                instr   <= '{opcode: hexv[15:0], addr: 16'(opnd)};
                issue_cyc = ncyc;
                if (model_run) model_exec(hexv[15:0], 16'(opnd));
            end else if (cmd == "E") begin
                // operand 0 takes the model value and 1 the literal column
                e.due   = 32'(issue_cyc + 3);
                e.vec   = (opnd == 1) ? hexv : model_out;
                e.store = flags[0];
                e.last  = flags[1];
                exp_q.push_back(e);
            end else if (cmd == "T") begin
                tries = 0;
                while (exp_q.size() > 0 && tries < 10) begin
                    idle_cycle();
                    tries++;
                end
                idle_cycle();
                if (exp_q.size() > 0) begin
                    $display("expected store never arrived in test %0d", opnd);
                    exp_q.delete();
                    err_total++;
                    test_err++;
                end
                tests++;
                if (test_err != 0) tests_failed++;
                $display("test %0d %s, %0d errors", opnd, (test_err == 0) ? "ok" : "bad",
                         test_err);
                test_err = 0;
            end else begin
                $display("unknown command %s in data file", cmd);
                err_total++;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("tests %0d, failed %0d, errors %0d", tests, tests_failed, err_total);
        if (err_total == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_hdc_input.txt
# cmd operand hex flags
# G addr item_count -, R level - -, I addr opcode gap, E src(0 model 1 literal) value store|last<<1, T test
G 0 10 0
G 1 10 0
G 2 10 0
G 3 10 0
G 4 10 0
G 5 10 0
G 6 10 0
G 7 10 0
G 8 10 0
G 8 8 0
G 9 10 0
R 1 0 0
I 0 01 1
I 0 20 1
E 0 0 1
I 1 01 1
I 0 20 1
E 0 0 1
I 7 01 1
I 0 20 1
E 0 0 1
I 8 01 1
I 0 20 1
E 0 0 1
I 9 01 1
I 0 20 1
E 0 0 1
T 1 0 0
I 3 02 1
I 0 20 1
E 0 0 1
I 0 04 1
I 0 20 1
E 0 0 1
I 100 01 1
I 0 20 1
E 1 0 1
T 2 0 0
I 1 02 1
I 0 40 1
I 2 01 1
I 0 04 1
I 0 10 1
I 0 80 1
E 0 0 3
T 3 0 0
I 1 02 0
I 0 40 0
I 2 01 0
I 0 04 0
I 0 10 0
I 0 80 0
E 0 0 3
T 4 0 0
R 0 0 0
R 1 0 0
I 5 01 1
I 0 10 1
I 0 20 1
E 0 0 1
T 5 0 0

// File: sim.f
+incdir+.
hdc_pkg.sv
hv_random_gen.sv
item_memory.sv
hdc_core.sv
hdc_top.sv
tb_hdc_top.sv

// File: Makefile
VERILATOR ?= verilator
TB_TOP    ?= tb_hdc_top
RTL_TOP   ?= hdc_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_STR  ?= Result: PASSED

RTL_SRCS = +incdir+. hdc_pkg.sv hv_random_gen.sv item_memory.sv hdc_core.sv hdc_top.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(RTL_SRCS) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(shell grep -v '^+' $(FILELIST)) tb_hdc_input.txt hdc_defines.svh
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_STR)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
